// ==== exec_unit.f ====
hdl/exec_pkg.sv
hdl/exec_regfile.sv
hdl/exec_alu.sv
hdl/exec_control.sv
hdl/exec_unit.sv
verif/exec_checker.sv
verif/exec_tb.sv

// ==== hdl/exec_alu.sv ====
/*
 * Combinational ALU with NZCV generation and 16-bit branch-condition vector.
 * SUB/SBC report C as no-borrow. Logic ops and MOV clear C and V.
 * Undefined opcodes give zero and pass the incoming flags through.
 */

`timescale 1ns/100ps

module exec_alu
    import exec_pkg::*;
(
    input  word_t     a_i,
    input  word_t     b_i,
    input  alu_op_e   op_i,
    input  nzcv_t     fl_i,
    output word_t     result_o,
    output nzcv_t     nzcv_o,
    output cond_vec_t cond_o
);

    logic                is_sub;
    logic                cin;
    word_t               b_eff;
    logic [DATA_W:0]     sum;
    logic                ovf;
    logic                n, z, c, v;

    // Subtraction as a + ~b + carry
    assign is_sub = (op_i == ALU_SUB) || (op_i == ALU_SBC);
    assign b_eff  = is_sub ? ~b_i : b_i;
    assign cin    = (op_i == ALU_SUB) ? 1'b1 :
                    (op_i == ALU_ADC || op_i == ALU_SBC) ? fl_i[1] : 1'b0;
    assign sum    = {1'b0, a_i} + {1'b0, b_eff} + {{DATA_W{1'b0}}, cin};
    assign ovf    = (a_i[DATA_W-1] == b_eff[DATA_W-1]) &&
                    (sum[DATA_W-1] != a_i[DATA_W-1]);

    always_comb begin
        result_o = '0;
        nzcv_o   = fl_i;
        case (op_i)
            ALU_MOV: result_o = b_i;
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC: result_o = sum[DATA_W-1:0];
            ALU_AND: result_o = a_i & b_i;
            ALU_OR:  result_o = a_i | b_i;
            ALU_XOR: result_o = a_i ^ b_i;
            default: result_o = '0;
        endcase
        case (op_i)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC:
                nzcv_o = {result_o[DATA_W-1], result_o == '0, sum[DATA_W], ovf};
            ALU_MOV, ALU_AND, ALU_OR, ALU_XOR:
                nzcv_o = {result_o[DATA_W-1], result_o == '0, 2'b00};
            default: nzcv_o = fl_i;
        endcase
    end

    assign {n, z, c, v} = nzcv_o;

    assign cond_o = {
        1'b1,            // Always
        z | (n ^ v),     // LE
        ~z & ~(n ^ v),   // GT
        n ^ v,           // LT
        ~(n ^ v),        // GE
        ~c | z,          // BE
        c & ~z,          // AB
        ~v,              // NV
        v,               // OV
        ~n,              // NS
        n,               // SS
        ~c,              // NC
        c,               // CS
        ~z,              // NE
        z,               // EQ
        1'b1             // Always
    };

endmodule

// ==== hdl/exec_control.sv ====
/*
 * Execute sequencing: FSM, operand muxing, PC, flags and memory port.
 * Requests are taken only in IDLE. One memory strobe per access, then wait
 * for ack; the memory side is assumed never to refuse a strobe.
 * Branch condition is sampled from the flags at acceptance.
 */

`timescale 1ns/100ps

module exec_control
    import exec_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_i,
    input  ctl_word_t ctl_i,
    output logic      rdy_o,
    output logic      flush_o,
    output word_t     newpc_o,
    output word_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      mem_we_o,
    output logic      mem_stb_o,
    input  logic      mem_ack_i,
    input  word_t     mem_rdata_i,
    output reg_addr_t ra_o,
    output reg_addr_t rb_o,
    input  word_t     rdata_a_i,
    input  word_t     rdata_b_i,
    output logic      we_o,
    output reg_addr_t wa_o,
    output word_t     wd_o,
    output word_t     op_a_o,
    output word_t     op_b_o,
    output alu_op_e   alu_op_o,
    output nzcv_t     fl_o,
    input  word_t     result_i,
    input  nzcv_t     nzcv_i,
    input  cond_vec_t cond_i
);

    typedef enum logic [2:0] {
        IDLE, TB1, TR1, TR2, TM1, TM2, TW2
    } exec_state_e;

    exec_state_e state;
    ctl_word_t   r_ctl, ctl;
    word_t       pc, flags, r_rdata;
    logic        busy;  // Strobe issued, ack pending

    imm_t        imm;
    reg_addr_t   rd, rm, rn;
    logic [3:0]  cond_idx;
    src_sel_e    src;
    dest_sel_e   dest;
    logic        is_store, use_imm, alu_write, jump;
    word_t       a_val, b_val, op2, br_target;

    // Live control word while idle, latched copy afterwards
    assign ctl      = (state == IDLE) ? ctl_i : r_ctl;
    assign imm      = ctl[CTL_IMM_HI:CTL_IMM_LO];
    assign rd       = ctl[CTL_RD_HI:CTL_RD_LO];
    assign rm       = ctl[CTL_RM_HI:CTL_RM_LO];
    assign rn       = ctl[CTL_RN_HI:CTL_RN_LO];
    assign cond_idx = ctl[CTL_COND_HI:CTL_COND_LO];
    assign src      = src_sel_e'(ctl[CTL_SRC_HI:CTL_SRC_LO]);
    assign dest     = dest_sel_e'(ctl[CTL_DST_HI:CTL_DST_LO]);

    assign is_store = (src == SRC_STI) || (src == SRC_STR);
    assign use_imm  = (src == SRC_IMM) || (src == SRC_STI);

    assign rdy_o = (state == IDLE);

    // Store data comes through port A in TR1
    assign ra_o  = (state == TR1 && is_store) ? rd : rm;
    assign rb_o  = rn;
    assign a_val = (ra_o == PC_REG) ? pc : rdata_a_i;  // r15 reads the PC
    assign b_val = (rb_o == PC_REG) ? pc : rdata_b_i;
    assign op2   = use_imm ? {{(DATA_W-IMM_W){1'b0}}, imm} : b_val;

    assign op_a_o   = ctl[CTL_REV] ? op2 : a_val;
    assign op_b_o   = ctl[CTL_REV] ? a_val : op2;
    assign alu_op_o = is_store ? ALU_ADD : alu_op_e'(ctl[CTL_ALUOP_HI:CTL_ALUOP_LO]);
    assign fl_o     = flags[31:28];

    assign br_target = pc + {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm} - 32'd4;

    // Result writeback from ALU (TR1) or load data (TW2)
    assign alu_write = (state == TR1) && !is_store && (dest == DST_RD);
    assign wa_o      = rd;
    assign wd_o      = (state == TW2) ? r_rdata : result_i;
    assign we_o      = (alu_write || state == TW2) && (rd != PC_REG);
    assign jump      = (alu_write || state == TW2) && (rd == PC_REG);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            pc        <= RESET_PC;
            flags     <= FLAGS_RESET;
            flush_o   <= 1'b0;
            mem_stb_o <= 1'b0;
            mem_we_o  <= 1'b0;
            busy      <= 1'b0;
        end else begin
            flush_o <= (state == TB1) || jump;  // Single-cycle pulse
            case (state)
                IDLE: if (req_i) begin
                    pc <= pc + 32'd4;
                    if (ctl[CTL_BRANCH]) begin
                        state <= flags[cond_idx] ? TB1 : IDLE;
                    end else begin
                        state <= TR1;
                    end
                end
                TB1: begin
                    pc    <= br_target;
                    state <= IDLE;
                end
                TR1: begin
                    if (alu_write && ctl[CTL_FLAG]) begin
                        flags <= {nzcv_i, 12'b0, cond_i};
                    end
                    if (jump) pc <= wd_o;
                    if (is_store)
                        state <= TR2;
                    else if (dest == DST_LOAD)
                        state <= TM1;
                    else
                        state <= IDLE;
                end
                TR2: state <= TM2;
                TM1, TM2: begin
                    if (!busy) begin
                        mem_stb_o <= 1'b1;
                        mem_we_o  <= (state == TM2);
                        busy      <= 1'b1;
                    end else begin
                        mem_stb_o <= 1'b0;
                        if (mem_ack_i) begin
                            busy     <= 1'b0;
                            mem_we_o <= 1'b0;
                            state    <= (state == TM1) ? TW2 : IDLE;
                        end
                    end
                end
                TW2: begin
                    if (jump) pc <= wd_o;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) r_ctl <= ctl_i;
        if (state == TB1) newpc_o <= br_target;
        if (jump) newpc_o <= wd_o;
        if (state == TR1) begin
            if (is_store)
                mem_wdata_o <= a_val;
            else if (dest == DST_LOAD)
                mem_addr_o <= result_i;  // Load address
        end
        if (state == TR2) mem_addr_o <= result_i;  // Store address
        if (state == TM1 && busy && mem_ack_i) r_rdata <= mem_rdata_i;
    end

endmodule

// ==== hdl/exec_pkg.sv ====
/*
 * Shared types and control-word layout for the execute stage.
 * Control word is 43 bits, fields packed from the top down as listed below.
 * ALU opcodes above XOR are undefined and yield zero with flags unchanged.
 */

package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 4;
    localparam int IMM_W      = 16;
    localparam int CTL_W      = 43;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [IMM_W-1:0]      imm_t;
    typedef logic [CTL_W-1:0]      ctl_word_t;
    typedef logic [3:0]            nzcv_t;
    typedef logic [15:0]           cond_vec_t;

    // Control word fields, msb first
    localparam int CTL_ALUOP_HI = 42;
    localparam int CTL_ALUOP_LO = 39;
    localparam int CTL_IMM_HI   = 38;
    localparam int CTL_IMM_LO   = 23;
    localparam int CTL_RD_HI    = 22;
    localparam int CTL_RD_LO    = 19;
    localparam int CTL_RM_HI    = 18;
    localparam int CTL_RM_LO    = 15;
    localparam int CTL_RN_HI    = 14;
    localparam int CTL_RN_LO    = 11;
    localparam int CTL_SRC_HI   = 10;
    localparam int CTL_SRC_LO   = 9;
    localparam int CTL_DST_HI   = 8;
    localparam int CTL_DST_LO   = 7;
    localparam int CTL_FLAG     = 6;  // Update flags from ALU
    localparam int CTL_BRANCH   = 5;  // Conditional relative branch
    localparam int CTL_COND_HI  = 4;
    localparam int CTL_COND_LO  = 1;
    localparam int CTL_REV      = 0;  // Swap ALU operands

    typedef enum logic [3:0] {
        ALU_MOV = 4'd0,
        ALU_ADD = 4'd1,
        ALU_ADC = 4'd2,
        ALU_SUB = 4'd3,
        ALU_SBC = 4'd4,
        ALU_AND = 4'd5,
        ALU_OR  = 4'd6,
        ALU_XOR = 4'd7
    } alu_op_e;

    // Operand source
    typedef enum logic [1:0] {
        SRC_REG = 2'd0,  // rm op rn
        SRC_IMM = 2'd1,  // rm op imm
        SRC_STI = 2'd2,  // store rd to rm+imm
        SRC_STR = 2'd3   // store rd to rm+rn
    } src_sel_e;

    // Result destination
    typedef enum logic [1:0] {
        DST_NONE = 2'd0,
        DST_RD   = 2'd1,
        DST_LOAD = 2'd2,  // rd <- mem[rm op operand2]
        DST_RSV  = 2'd3   // Behaves as NONE
    } dest_sel_e;

    // NZCV in 31:28, condition vector in 15:0, both always-true bits set
    localparam word_t FLAGS_RESET = 32'h0000_8001;

    localparam reg_addr_t PC_REG = 4'd15;

endpackage

// ==== hdl/exec_regfile.sv ====
/*
 * General registers r0..r14, two async reads and one sync write.
 * Index 15 is not stored and reads as zero; the PC lives in exec_control.
 */

`timescale 1ns/100ps

module exec_regfile
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t ra_i,
    input  reg_addr_t rb_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o,
    input  logic      we_i,
    input  reg_addr_t wa_i,
    input  word_t     wd_i
);

    localparam int NUM_REGS = 15;

    word_t regs [0:NUM_REGS-1];

    // Index 15 falls outside the array
    assign rdata_a_o = (ra_i == PC_REG) ? '0 : regs[ra_i];
    assign rdata_b_o = (rb_i == PC_REG) ? '0 : regs[rb_i];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != PC_REG) begin
            regs[wa_i] <= wd_i;
        end
    end

endmodule

// ==== hdl/exec_unit.sv ====
/*
 * Execute stage top level. Decode handshake is req/rdy, memory is stb/ack.
 * RESET_PC sets the program counter after reset.
 */

`timescale 1ns/100ps

module exec_unit
    import exec_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_i,
    input  ctl_word_t ctl_i,
    output logic      rdy_o,
    output logic      flush_o,
    output word_t     newpc_o,
    output word_t     mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      mem_we_o,
    output logic      mem_stb_o,
    input  logic      mem_ack_i,
    input  word_t     mem_rdata_i
);

    reg_addr_t ra, rb, wa;
    word_t     rdata_a, rdata_b, wd;
    logic      we;
    word_t     op_a, op_b, result;
    alu_op_e   alu_op;
    nzcv_t     fl, nzcv;
    cond_vec_t cond;

    exec_control #(
        .RESET_PC (RESET_PC)
    ) u_control (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req_i),
        .ctl_i       (ctl_i),
        .rdy_o       (rdy_o),
        .flush_o     (flush_o),
        .newpc_o     (newpc_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_we_o    (mem_we_o),
        .mem_stb_o   (mem_stb_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i),
        .ra_o        (ra),
        .rb_o        (rb),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .we_o        (we),
        .wa_o        (wa),
        .wd_o        (wd),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .alu_op_o    (alu_op),
        .fl_o        (fl),
        .result_i    (result),
        .nzcv_i      (nzcv),
        .cond_i      (cond)
    );

    exec_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .ra_i      (ra),
        .rb_i      (rb),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .we_i      (we),
        .wa_i      (wa),
        .wd_i      (wd)
    );

    exec_alu u_alu (
        .a_i      (op_a),
        .b_i      (op_b),
        .op_i     (alu_op),
        .fl_i     (fl),
        .result_o (result),
        .nzcv_o   (nzcv),
        .cond_o   (cond)
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the exec_unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module exec_tb \
    -f exec_unit.f \
    -o exec_sim

./obj_dir/exec_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== verif/exec_checker.sv ====
/*
 * Architectural model of the execute stage, driven from DUT ports only.
 * Checks rdy_o, flush_o/newpc_o and each memory strobe against the model.
 * Assumes loads never target r15 and RESET_PC matches the DUT.
 */

`timescale 1ns/100ps

module exec_checker
    import exec_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_i,
    input  ctl_word_t ctl_i,
    input  logic      rdy_o,
    input  logic      flush_o,
    input  word_t     newpc_o,
    input  word_t     mem_addr_o,
    input  word_t     mem_wdata_o,
    input  logic      mem_we_o,
    input  logic      mem_stb_o,
    input  logic      mem_ack_i,
    input  word_t     mem_rdata_i,
    output int        err_count_o
);

    localparam int    NEVER = 2147483647;
    localparam longint SMAX = 64'sd2147483647;
    localparam longint SMIN = -64'sd2147483648;

    word_t     regs [0:14];
    word_t     pc_m, flags_m;
    int        cyc, ready_at, flush_due, errors;
    word_t     exp_newpc, exp_addr, exp_wdata;
    logic      exp_we, stb_due, ack_due, load_pend;
    reg_addr_t load_rd;

    assign err_count_o = errors;

    function automatic word_t read_reg(reg_addr_t idx);
        if (idx == PC_REG) return pc_m;  // r15 reads the incremented pc
        return regs[idx];
    endfunction

    // Branch conditions from NZCV, bit 0 and bit 15 always set
    function automatic cond_vec_t cond_ref(nzcv_t f);
        logic n, z, c, v;
        cond_vec_t cv;
        {n, z, c, v} = f;
        cv[0]  = 1'b1;
        cv[1]  = z;
        cv[2]  = ~z;
        cv[3]  = c;
        cv[4]  = ~c;
        cv[5]  = n;
        cv[6]  = ~n;
        cv[7]  = v;
        cv[8]  = ~v;
        cv[9]  = c & ~z;
        cv[10] = ~c | z;
        cv[11] = (n == v);
        cv[12] = (n != v);
        cv[13] = ~z & (n == v);
        cv[14] = z | (n != v);
        cv[15] = 1'b1;
        return cv;
    endfunction

    // Returns {nzcv, result}
    function automatic logic [35:0] alu_ref(word_t a, word_t b, logic [3:0] op, nzcv_t fl);
        longint          sa, sb, sres;
        longint unsigned ua, ub, need;
        logic            cin;
        word_t           r;
        nzcv_t           f;
        sa   = longint'($signed(a));
        sb   = longint'($signed(b));
        ua   = {32'b0, a};
        ub   = {32'b0, b};
        f    = fl;
        r    = '0;
        sres = 0;
        case (op)
            4'd1, 4'd2: begin
                cin  = (op == 4'd2) ? fl[1] : 1'b0;
                r    = a + b + {31'b0, cin};
                sres = cin ? sa + sb + 1 : sa + sb;
                f[1] = (cin ? ua + ub + 64'd1 : ua + ub) > 64'h0000_0000_FFFF_FFFF;
                f[0] = (sres > SMAX) || (sres < SMIN);
            end
            4'd3, 4'd4: begin
                cin  = (op == 4'd4) ? ~fl[1] : 1'b0;  // Borrow in
                r    = a - b - {31'b0, cin};
                sres = cin ? sa - sb - 1 : sa - sb;
                need = cin ? ub + 64'd1 : ub;
                f[1] = (ua >= need);  // No borrow
                f[0] = (sres > SMAX) || (sres < SMIN);
            end
            4'd0: r = b;
            4'd5: r = a & b;
            4'd6: r = a | b;
            4'd7: r = a ^ b;
            default: r = '0;
        endcase
        if (op <= 4'd7) begin
            f[3] = r[31];
            f[2] = (r == '0);
            if (op == 4'd0 || op >= 4'd5) f[1:0] = 2'b00;
        end
        return {f, r};
    endfunction

    task automatic report_mismatch(string name, word_t exp, word_t got);
        $display("** Error %s exp %h got %h", name, exp, got);
        errors++;
    endtask

    task automatic report_fault(string what);
        $display("** Error at cycle %0d: %s", cyc, what);
        errors++;
    endtask

    initial errors = 0;

    always @(posedge clk) begin
        ctl_word_t   c;
        reg_addr_t   rd, rm, rn;
        logic [1:0]  src, dst;
        imm_t        imm;
        word_t       a, op2;
        logic [35:0] res;
        logic        exp_flush;
        if (reset) begin
            for (int i = 0; i < 15; i++) regs[i] = '0;
            pc_m      = RESET_PC;
            flags_m   = FLAGS_RESET;
            cyc       = 0;
            ready_at  = 0;
            flush_due = -10;
            stb_due   = 1'b0;
            ack_due   = 1'b0;
            load_pend = 1'b0;
        end else begin
            if (rdy_o !== (cyc >= ready_at)) report_mismatch("rdy_o", {31'b0, cyc >= ready_at}, {31'b0, rdy_o});
            exp_flush = (cyc == flush_due);
            if (flush_o !== exp_flush) report_mismatch("flush_o", {31'b0, exp_flush}, {31'b0, flush_o});
            if (exp_flush && newpc_o !== exp_newpc) report_mismatch("newpc_o", exp_newpc, newpc_o);
            if (mem_stb_o) begin
                if (!stb_due) begin
                    report_fault("memory strobe with no access outstanding");
                end else begin
                    if (mem_addr_o !== exp_addr) report_mismatch("mem_addr_o", exp_addr, mem_addr_o);
                    if (mem_we_o !== exp_we) report_mismatch("mem_we_o", {31'b0, exp_we}, {31'b0, mem_we_o});
                    if (exp_we && mem_wdata_o !== exp_wdata) report_mismatch("mem_wdata_o", exp_wdata, mem_wdata_o);
                    stb_due = 1'b0;
                    ack_due = 1'b1;
                end
            end
            if (mem_ack_i) begin
                if (!ack_due) begin
                    report_fault("memory ack with no strobe outstanding");
                end else begin
                    ack_due = 1'b0;
                    if (load_pend) begin
                        if (load_rd != PC_REG) regs[load_rd] = mem_rdata_i;
                        ready_at = cyc + 2;  // Through TW2
                    end else begin
                        ready_at = cyc + 1;
                    end
                end
            end
            if (req_i && rdy_o) begin
                c    = ctl_i;
                imm  = c[CTL_IMM_HI:CTL_IMM_LO];
                rd   = c[CTL_RD_HI:CTL_RD_LO];
                rm   = c[CTL_RM_HI:CTL_RM_LO];
                rn   = c[CTL_RN_HI:CTL_RN_LO];
                src  = c[CTL_SRC_HI:CTL_SRC_LO];
                dst  = c[CTL_DST_HI:CTL_DST_LO];
                pc_m = pc_m + 32'd4;
                if (c[CTL_BRANCH]) begin
                    if (flags_m[c[CTL_COND_HI:CTL_COND_LO]]) begin
                        pc_m      = pc_m + {{16{imm[15]}}, imm} - 32'd4;
                        exp_newpc = pc_m;
                        flush_due = cyc + 2;
                        ready_at  = cyc + 2;
                    end else begin
                        ready_at = cyc + 1;
                    end
                end else begin
                    a   = read_reg(rm);
                    op2 = (src == SRC_IMM || src == SRC_STI) ? {16'b0, imm} : read_reg(rn);
                    if (src == SRC_STI || src == SRC_STR) begin
                        exp_wdata = read_reg(rd);
                        exp_addr  = a + op2;
                        exp_we    = 1'b1;
                        stb_due   = 1'b1;
                        load_pend = 1'b0;
                        ready_at  = NEVER;
                    end else begin
                        if (c[CTL_REV]) res = alu_ref(op2, a, c[CTL_ALUOP_HI:CTL_ALUOP_LO], flags_m[31:28]);
                        else res = alu_ref(a, op2, c[CTL_ALUOP_HI:CTL_ALUOP_LO], flags_m[31:28]);
                        ready_at = cyc + 2;
                        if (dst == DST_RD) begin
                            if (rd == PC_REG) begin
                                pc_m      = res[31:0];  // Jump
                                exp_newpc = pc_m;
                                flush_due = cyc + 2;
                            end else begin
                                regs[rd] = res[31:0];
                            end
                            if (c[CTL_FLAG]) flags_m = {res[35:32], 12'b0, cond_ref(res[35:32])};
                        end else if (dst == DST_LOAD) begin
                            exp_addr  = res[31:0];
                            exp_we    = 1'b0;
                            stb_due   = 1'b1;
                            load_pend = 1'b1;
                            load_rd   = rd;
                            ready_at  = NEVER;
                        end
                    end
                end
            end
            cyc++;
        end
    end

endmodule

// ==== verif/exec_tb.sv ====
/*
 * Testbench for exec_unit: random ALU ops, branches, loads, stores and jumps.
 * A 256-word memory answers strobes after 1 to 4 cycles, indexed by addr[9:2].
 */

`timescale 1ns/100ps

module exec_tb
    import exec_pkg::*;
();

    localparam word_t RESET_PC   = 32'h0000_1000;
    localparam int    CLK_PERIOD = 100;
    localparam int    N_ALU      = 40;
    localparam int    N_BR       = 32;
    localparam int    N_LD       = 16;
    localparam int    N_JMP      = 4;
    localparam int    N_INSTR    = 1 + 2 * N_ALU + 2 * N_BR + 2 * N_LD + 3 * N_JMP;
    localparam int    MAX_CYCLES = N_INSTR * 20;

    logic      clk;
    logic      reset;
    logic      req_i;
    ctl_word_t ctl_i;
    logic      rdy_o, flush_o, mem_we_o, mem_stb_o;
    word_t     newpc_o, mem_addr_o, mem_wdata_o;
    logic      mem_ack_i   = 1'b0;
    word_t     mem_rdata_i = '0;
    int        err_count;
    int        issued;

    word_t      mem [0:255];
    logic       pend, acc_we;
    logic [2:0] wait_cnt;
    logic [7:0] acc_idx;
    word_t      acc_wdata;

    exec_unit #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .reset(reset), .req_i(req_i), .ctl_i(ctl_i), .rdy_o(rdy_o),
        .flush_o(flush_o), .newpc_o(newpc_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_we_o(mem_we_o), .mem_stb_o(mem_stb_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i)
    );

    exec_checker #(.RESET_PC(RESET_PC)) u_checker (
        .clk(clk), .reset(reset), .req_i(req_i), .ctl_i(ctl_i), .rdy_o(rdy_o),
        .flush_o(flush_o), .newpc_o(newpc_o), .mem_addr_o(mem_addr_o),
        .mem_wdata_o(mem_wdata_o), .mem_we_o(mem_we_o), .mem_stb_o(mem_stb_o),
        .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i), .err_count_o(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory responder acks 1..4 cycles after the strobe
    always @(posedge clk) begin
        int unsigned dly;
        logic [7:0]  k;
        if (reset) begin
            for (int i = 0; i < 256; i++) begin
                k = i[7:0];
                mem[i] <= {8'hA5, k, ~k, k ^ 8'h3C};  // Fill pattern
            end
            mem_ack_i <= 1'b0;
            pend      <= 1'b0;
            wait_cnt  <= 3'd0;
        end else begin
            mem_ack_i <= 1'b0;
            if (mem_stb_o) begin
                dly       = $urandom_range(4, 1);
                wait_cnt  <= dly[2:0];
                pend      <= 1'b1;
                acc_idx   <= mem_addr_o[9:2];
                acc_we    <= mem_we_o;
                acc_wdata <= mem_wdata_o;
            end else if (pend) begin
                if (wait_cnt == 3'd1) begin
                    mem_ack_i <= 1'b1;
                    pend      <= 1'b0;
                    if (acc_we) mem[acc_idx] <= acc_wdata;
                    else mem_rdata_i <= mem[acc_idx];
                end else begin
                    wait_cnt <= wait_cnt - 3'd1;
                end
            end
        end
    end

    function automatic ctl_word_t make_ctl(logic [3:0] op, imm_t imm, reg_addr_t rd,
                                           reg_addr_t rm, reg_addr_t rn, logic [1:0] src,
                                           logic [1:0] dst, logic flag, logic br,
                                           logic [3:0] cond, logic rev);
        ctl_word_t c;
        c = '0;
        c[CTL_ALUOP_HI:CTL_ALUOP_LO] = op;
        c[CTL_IMM_HI:CTL_IMM_LO]     = imm;
        c[CTL_RD_HI:CTL_RD_LO]       = rd;
        c[CTL_RM_HI:CTL_RM_LO]       = rm;
        c[CTL_RN_HI:CTL_RN_LO]       = rn;
        c[CTL_SRC_HI:CTL_SRC_LO]     = src;
        c[CTL_DST_HI:CTL_DST_LO]     = dst;
        c[CTL_FLAG]                  = flag;
        c[CTL_BRANCH]                = br;
        c[CTL_COND_HI:CTL_COND_LO]   = cond;
        c[CTL_REV]                   = rev;
        return c;
    endfunction

    // Store rd to a word offset from r0, which stays zero
    function automatic ctl_word_t store_ctl(reg_addr_t rd, logic [7:0] word_idx);
        return make_ctl(4'd0, {6'b0, word_idx, 2'b00}, rd, 4'd0, 4'd0, SRC_STI,
                        DST_NONE, 1'b0, 1'b0, 4'd0, 1'b0);
    endfunction

    function automatic reg_addr_t pick_gpr();
        int unsigned r;
        r = $urandom_range(14, 1);
        return r[3:0];
    endfunction

    task automatic issue(ctl_word_t c);
        do @(negedge clk); while (!rdy_o);
        @(posedge clk);
        req_i <= 1'b1;
        ctl_i <= c;
        @(posedge clk);  // Accepted here
        req_i <= 1'b0;
        issued++;
    endtask

    initial begin
        int unsigned r0, r1, r2;
        reg_addr_t   dreg;
        logic [3:0]  cnd;
        void'($urandom(32'hbb1123b0));
        issued = 0;
        reset  = 1'b1;
        req_i  = 1'b0;
        ctl_i  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        issue(store_ctl(4'd0, 8'h10));
        for (int i = 0; i < N_ALU; i++) begin
            r0   = $urandom;
            r1   = $urandom;
            r2   = $urandom;
            dreg = pick_gpr();
            issue(make_ctl({1'b0, r0[2:0]}, r1[15:0], dreg, r0[7:4], r0[11:8],
                           {1'b0, r0[12]}, DST_RD, r0[13], 1'b0, 4'd0, r0[14]));
            issue(store_ctl(dreg, r2[7:0]));
        end
        cnd = 4'd0;
        for (int i = 0; i < N_BR; i++) begin
            r0 = $urandom;
            r1 = $urandom;
            issue(make_ctl({1'b0, r0[2:0]}, r1[31:16], pick_gpr(), r0[7:4], r0[11:8],
                           {1'b0, r0[12]}, DST_RD, 1'b1, 1'b0, 4'd0, r0[14]));
            issue(make_ctl(4'd0, r1[15:0], 4'd0, 4'd0, 4'd0, SRC_REG, DST_NONE,
                           1'b0, 1'b1, cnd, 1'b0));
            cnd = cnd + 4'd1;
        end
        for (int i = 0; i < N_LD; i++) begin
            r0   = $urandom;
            r2   = $urandom;
            dreg = pick_gpr();
            issue(make_ctl(ALU_ADD, {6'b0, r0[9:2], 2'b00}, dreg, 4'd0, 4'd0, SRC_IMM,
                           DST_LOAD, 1'b0, 1'b0, 4'd0, r0[0]));
            issue(store_ctl(dreg, r2[7:0]));
        end
        for (int i = 0; i < N_JMP; i++) begin
            r1   = $urandom;
            r2   = $urandom;
            dreg = pick_gpr();
            issue(make_ctl(ALU_MOV, {r1[13:0], 2'b00}, PC_REG, 4'd0, 4'd0, SRC_IMM,
                           DST_RD, 1'b0, 1'b0, 4'd0, 1'b0));
            issue(make_ctl(ALU_ADD, 16'h0000, dreg, PC_REG, 4'd0, SRC_IMM, DST_RD,
                           1'b0, 1'b0, 4'd0, 1'b0));
            issue(store_ctl(dreg, r2[7:0]));
        end
        do @(negedge clk); while (!rdy_o);
        repeat (4) @(posedge clk);
        $display("Requests issued: %0d, errors: %0d", issued, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
